// ==== acq_pkg.sv ====
package acq_pkg;

   // -------------------------------------------------------------------
   // Register bus
   // -------------------------------------------------------------------

   // Width of the register data bus
   localparam int BUS_WIDTH = 8;

   // Register map of the acquisition unit
   typedef enum logic [1:0] {
      // Raw stream read-back slot, reads zero in this unit
      AQ_STREAM    = 2'd0,
      AQ_RESERVED1 = 2'd1,
      AQ_RESERVED2 = 2'd2,
      // Status and control
      AQ_SYSTEM    = 2'd3
   } acq_addr_e;

   // Bit positions within the system register
   // Acquisition enable (R/W)
   localparam int SYS_ENABLE    = 7;
   // Packetizer streaming (RO)
   localparam int SYS_ACTIVE    = 6;
   // Sticky overflow (RO, write one to clear)
   localparam int SYS_OFLOW     = 3;
   // Packetizer state field (RO)
   localparam int SYS_STATE_MSB = 2;
   localparam int SYS_STATE_LSB = 0;

   // -------------------------------------------------------------------
   // Packetizer
   // -------------------------------------------------------------------

   // Stream FSM states, as seen in the status register
   typedef enum logic [2:0] {
      PKT_IDLE   = 3'd0,
      PKT_STREAM = 3'd1,
      PKT_GAP    = 3'd2
   } pkt_state_e;

endpackage

// ==== acq_regs.sv ====
module acq_regs
   import acq_pkg::*;
(
   input  logic                 clock_i,
   input  logic                 M_AXIS_ARESETN,

   // Pipelined register bus
   input  logic                 cyc_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  acq_addr_e            adr_i,
   input  logic [BUS_WIDTH-1:0] dat_i,
   output logic                 ack_o,
   output logic [BUS_WIDTH-1:0] dat_o,

   // Status inputs from the datapath
   input  logic                 drop_i,
   input  pkt_state_e           state_i,

   // Control and status outputs
   output logic                 enable_o,
   output logic                 oflow_o
);

   // A transfer is any cycle with both cycle and strobe high
   logic                 request;
   logic                 store;
   logic                 fetch;
   logic                 sys_store;
   logic [BUS_WIDTH-1:0] status;

   assign request   = cyc_i && stb_i;
   assign store     = request && we_i;
   assign fetch     = request && !we_i;

   // Only the system register accepts writes
   assign sys_store = store && (adr_i == AQ_SYSTEM);

   // -------------------------------------------------------------------
   // Status byte
   // -------------------------------------------------------------------
   always_comb
   begin
      status                              = '0;
      status[SYS_ENABLE]                  = enable_o;
      // Active whenever the packetizer is in its streaming state
      status[SYS_ACTIVE]                  = (state_i == PKT_STREAM);
      status[SYS_OFLOW]                   = oflow_o;
      status[SYS_STATE_MSB:SYS_STATE_LSB] = state_i;
   end

   // -------------------------------------------------------------------
   // Bus response
   // -------------------------------------------------------------------

   // One ack per request, one cycle later
   // Back-to-back requests give back-to-back acks
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         ack_o <= 1'b0;
      end
      else
      begin
         ack_o <= request;
      end
   end

   // Read data lines up with the ack
   always_ff @(posedge clock_i)
   begin
      if (fetch)
      begin
         case (adr_i)
            AQ_SYSTEM:
            begin
               dat_o <= status;
            end
            // Stream slot and spare addresses read zero
            AQ_STREAM, AQ_RESERVED1, AQ_RESERVED2:
            begin
               dat_o <= '0;
            end
         endcase
      end
   end

   // -------------------------------------------------------------------
   // Control state
   // -------------------------------------------------------------------

   // Enable bit, written at the same edge that registers the ack
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         enable_o <= 1'b0;
      end
      else if (sys_store)
      begin
         enable_o <= dat_i[SYS_ENABLE];
      end
   end

   // Sticky overflow flag
   // A drop in the same cycle as a clear wins
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         oflow_o <= 1'b0;
      end
      else if (drop_i)
      begin
         oflow_o <= 1'b1;
      end
      else if (sys_store && dat_i[SYS_OFLOW])
      begin
         oflow_o <= 1'b0;
      end
   end

endmodule

// ==== sample_fifo.sv ====
module sample_fifo #(
   parameter int SAMPLE_WIDTH = 24,
   parameter int FIFO_ABITS   = 4
) (
   input  logic                    clock_i,
   input  logic                    M_AXIS_ARESETN,

   // Write side
   input  logic                    wr_i,
   input  logic [SAMPLE_WIDTH-1:0] data_i,
   output logic                    drop_o,

   // Read side, head shown before the read strobe
   input  logic                    rd_i,
   output logic [SAMPLE_WIDTH-1:0] data_o,
   output logic                    empty_o
);

   localparam int DEPTH = 1 << FIFO_ABITS;

   // Sample storage
   logic [SAMPLE_WIDTH-1:0] mem [DEPTH];

   // Pointers carry one extra wrap bit
   logic [FIFO_ABITS:0]     wr_ptr;
   logic [FIFO_ABITS:0]     rd_ptr;
   logic                    full;
   logic                    push;
   logic                    pop;

   // -------------------------------------------------------------------
   // Flags
   // -------------------------------------------------------------------

   // Empty when the pointers match exactly
   assign empty_o = (wr_ptr == rd_ptr);

   // Full when the addresses match but the wrap bits differ
   assign full    = (wr_ptr[FIFO_ABITS] != rd_ptr[FIFO_ABITS]) &&
                    (wr_ptr[FIFO_ABITS-1:0] == rd_ptr[FIFO_ABITS-1:0]);

   // Writes are refused while full
   // A read in the same cycle does not make room
   assign push    = wr_i && !full;
   assign drop_o  = wr_i && full;

   // Never pop an empty FIFO
   assign pop     = rd_i && !empty_o;

   // First-word fall-through head
   assign data_o  = mem[rd_ptr[FIFO_ABITS-1:0]];

   // -------------------------------------------------------------------
   // Storage and pointers
   // -------------------------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (push)
      begin
         mem[wr_ptr[FIFO_ABITS-1:0]] <= data_i;
      end
   end

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // Head leaves at the edge of the read
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== axis_packetizer.sv ====
module axis_packetizer
   import acq_pkg::*;
#(
   parameter int SAMPLE_WIDTH = 24,
   parameter int TDATA_WIDTH  = 32,
   parameter int PKT_WORDS    = 8
) (
   input  logic                    clock_i,
   input  logic                    M_AXIS_ARESETN,

   // FIFO read side
   input  logic [SAMPLE_WIDTH-1:0] data_i,
   input  logic                    empty_i,
   output logic                    rd_o,

   // FSM state for the status register
   output pkt_state_e              state_o,

   // AXI-Stream master
   output logic                    M_AXIS_TVALID,
   output logic [TDATA_WIDTH-1:0]  M_AXIS_TDATA,
   output logic                    M_AXIS_TLAST,
   input  logic                    M_AXIS_TREADY
);

   // Counter wide enough for a packet, at least one bit
   localparam int CNT_BITS = (PKT_WORDS > 1) ? $clog2(PKT_WORDS) : 1;
   localparam logic [CNT_BITS-1:0] LAST_WORD = CNT_BITS'(PKT_WORDS - 1);

   pkt_state_e          state;
   logic [CNT_BITS-1:0] word_cnt;
   logic                handshake;

   // -------------------------------------------------------------------
   // Stream outputs
   // -------------------------------------------------------------------

   // Offer a word whenever streaming and the FIFO has one
   assign M_AXIS_TVALID = (state == PKT_STREAM) && !empty_i;

   // The head and the counter only move on a handshake
   // so data and last hold still under back-pressure
   assign M_AXIS_TDATA  = TDATA_WIDTH'(data_i);
   assign M_AXIS_TLAST  = M_AXIS_TVALID && (word_cnt == LAST_WORD);

   assign handshake     = M_AXIS_TVALID && M_AXIS_TREADY;

   // Pop the FIFO on every accepted word
   assign rd_o          = handshake;
   assign state_o       = state;

   // -------------------------------------------------------------------
   // Packet FSM
   // -------------------------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         state    <= PKT_IDLE;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            // Start streaming right after reset
            PKT_IDLE:
            begin
               state <= PKT_STREAM;
            end
            PKT_STREAM:
            begin
               if (handshake)
               begin
                  if (word_cnt == LAST_WORD)
                  begin
                     state <= PKT_GAP;
                  end
                  else
                  begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            // Single idle cycle between packets
            PKT_GAP:
            begin
               word_cnt <= '0;
               state    <= PKT_STREAM;
            end
            default:
            begin
               state <= PKT_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== raw_acquire.sv ====
module raw_acquire
   import acq_pkg::*;
#(
   parameter int SAMPLE_WIDTH = 24,
   parameter int FIFO_ABITS   = 4,
   parameter int PKT_WORDS    = 8,
   parameter int TDATA_WIDTH  = 32
) (
   input  logic                    clock_i,
   input  logic                    M_AXIS_ARESETN,

   // Sampler interface
   input  logic                    locked_i,
   input  logic                    strobe_i,
   input  logic [SAMPLE_WIDTH-1:0] signal_i,

   // Pipelined register bus
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  logic [1:0]              adr_i,
   input  logic [BUS_WIDTH-1:0]    dat_i,
   output logic                    ack_o,
   output logic [BUS_WIDTH-1:0]    dat_o,

   // AXI-Stream master
   output logic                    M_AXIS_TVALID,
   output logic [TDATA_WIDTH-1:0]  M_AXIS_TDATA,
   output logic                    M_AXIS_TLAST,
   input  logic                    M_AXIS_TREADY,

   // Debug and status
   output logic                    enabled_o,
   output logic                    oflow_o,
   output logic [2:0]              state_o
);

   logic                    enable;
   logic                    capture;
   logic [SAMPLE_WIDTH-1:0] fifo_data;
   logic                    fifo_empty;
   logic                    fifo_drop;
   logic                    fifo_rd;
   pkt_state_e              pkt_state;

   // Capture only while enabled and the sampler is locked
   assign capture   = enable && locked_i && strobe_i;

   assign enabled_o = enable;
   assign state_o   = pkt_state;

   // Control and status registers
   acq_regs u_regs (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (acq_addr_e'(adr_i)),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .drop_i         (fifo_drop),
      .state_i        (pkt_state),
      .enable_o       (enable),
      .oflow_o        (oflow_o)
   );

   // Sample buffer between capture and stream
   sample_fifo #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH),
      .FIFO_ABITS   (FIFO_ABITS)
   ) u_fifo (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .wr_i           (capture),
      .data_i         (signal_i),
      .drop_o         (fifo_drop),
      .rd_i           (fifo_rd),
      .data_o         (fifo_data),
      .empty_o        (fifo_empty)
   );

   // Fixed-length packets out
   axis_packetizer #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH),
      .TDATA_WIDTH  (TDATA_WIDTH),
      .PKT_WORDS    (PKT_WORDS)
   ) u_packetizer (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .data_i         (fifo_data),
      .empty_i        (fifo_empty),
      .rd_o           (fifo_rd),
      .state_o        (pkt_state),
      .M_AXIS_TVALID  (M_AXIS_TVALID),
      .M_AXIS_TDATA   (M_AXIS_TDATA),
      .M_AXIS_TLAST   (M_AXIS_TLAST),
      .M_AXIS_TREADY  (M_AXIS_TREADY)
   );

endmodule

// ==== tb_raw_acquire.sv ====
module tb_raw_acquire
   import acq_pkg::*;
();

   localparam int SAMPLE_WIDTH = 24;
   localparam int TDATA_WIDTH  = 32;
   localparam int FIFO_ABITS   = 4;
   localparam int PKT_WORDS    = 8;
   localparam int FIFO_DEPTH   = 1 << FIFO_ABITS;
   localparam int RAND_CYCLES  = 600;
   // Random phase plus the fixed phases and the drains
   localparam int STIM_CYCLES  = RAND_CYCLES + 250;

   logic                    clock_i = 1'b0;
   logic                    M_AXIS_ARESETN;
   logic                    locked_i;
   logic                    strobe_i;
   logic [SAMPLE_WIDTH-1:0] signal_i;
   logic                    cyc_i;
   logic                    stb_i;
   logic                    we_i;
   logic [1:0]              adr_i;
   logic [BUS_WIDTH-1:0]    dat_i;
   logic                    ack_o;
   logic [BUS_WIDTH-1:0]    dat_o;
   logic                    M_AXIS_TVALID;
   logic [TDATA_WIDTH-1:0]  M_AXIS_TDATA;
   logic                    M_AXIS_TLAST;
   logic                    M_AXIS_TREADY;
   logic                    enabled_o;
   logic                    oflow_o;
   logic [2:0]              state_o;

   // Reference model
   logic [SAMPLE_WIDTH-1:0] ref_q [$];
   logic                    model_en;
   logic                    model_oflow;
   pkt_state_e              model_state;
   int                      word_cnt;

   // Values carried over from the previous cycle
   logic                    prev_req;
   logic                    prev_rd;
   logic                    prev_stall;
   logic                    prev_tlast;
   logic [TDATA_WIDTH-1:0]  prev_tdata;
   logic [BUS_WIDTH-1:0]    exp_dat;

   logic [31:0]             rng;

   raw_acquire #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH),
      .FIFO_ABITS   (FIFO_ABITS),
      .PKT_WORDS    (PKT_WORDS),
      .TDATA_WIDTH  (TDATA_WIDTH)
   ) dut (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .locked_i       (locked_i),
      .strobe_i       (strobe_i),
      .signal_i       (signal_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .M_AXIS_TVALID  (M_AXIS_TVALID),
      .M_AXIS_TDATA   (M_AXIS_TDATA),
      .M_AXIS_TLAST   (M_AXIS_TLAST),
      .M_AXIS_TREADY  (M_AXIS_TREADY),
      .enabled_o      (enabled_o),
      .oflow_o        (oflow_o),
      .state_o        (state_o)
   );

   always #2 clock_i = ~clock_i;

   // -------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------

   // 32-bit xorshift generator
   function automatic logic [31:0] xorshift(input logic [31:0] seed);
      logic [31:0] x;
      x = seed;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Request stays up for exactly one cycle per call
   task automatic bus_issue(input logic we, input logic [1:0] adr, input logic [7:0] dat);
      @(posedge clock_i);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= we;
      adr_i <= adr;
      dat_i <= dat;
   endtask

   task automatic bus_release();
      @(posedge clock_i);
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      we_i  <= 1'b0;
   endtask

   // Samples with a fixed lock and ready, strobe random or held high
   task automatic drive_samples(input int cycles, input logic lock,
                                input logic strobe_rand, input logic ready);
      repeat (cycles)
      begin
         @(posedge clock_i);
         rng = xorshift(rng);
         locked_i      <= lock;
         strobe_i      <= strobe_rand ? rng[0] : 1'b1;
         signal_i      <= rng[31:8];
         M_AXIS_TREADY <= ready;
      end
   endtask

   // Random strobe, lock, ready and register reads
   task automatic random_traffic(input int cycles);
      repeat (cycles)
      begin
         @(posedge clock_i);
         rng = xorshift(rng);
         strobe_i      <= rng[0];
         M_AXIS_TREADY <= rng[1];
         // Lock drops out about one cycle in sixteen
         locked_i      <= (rng[5:2] != 4'h0);
         cyc_i         <= (rng[8:6] == 3'd0);
         stb_i         <= (rng[8:6] == 3'd0);
         we_i          <= 1'b0;
         adr_i         <= rng[10:9];
         rng = xorshift(rng);
         signal_i      <= rng[SAMPLE_WIDTH-1:0];
      end
   endtask

   // Stop captures and accept every word until the model is empty
   task automatic drain_stream();
      @(posedge clock_i);
      strobe_i      <= 1'b0;
      cyc_i         <= 1'b0;
      stb_i         <= 1'b0;
      M_AXIS_TREADY <= 1'b1;
      while (ref_q.size() != 0)
      begin
         @(posedge clock_i);
      end
   endtask

   // -------------------------------------------------------------------
   // Checker, on the falling edge where everything is settled
   // -------------------------------------------------------------------
   always @(negedge clock_i)
   begin
      logic capture;
      logic drop;
      logic handshake;
      logic sys_wr;
      if (!M_AXIS_ARESETN)
      begin
         check_value("M_AXIS_TVALID", M_AXIS_TVALID, 0);
         check_value("M_AXIS_TLAST", M_AXIS_TLAST, 0);
         check_value("ack_o", ack_o, 0);
         check_value("enabled_o", enabled_o, 0);
         check_value("oflow_o", oflow_o, 0);
         check_value("state_o", state_o, PKT_IDLE);
         ref_q.delete();
         model_en    = 1'b0;
         model_oflow = 1'b0;
         model_state = PKT_IDLE;
         word_cnt    = 0;
         prev_req    = 1'b0;
         prev_rd     = 1'b0;
         prev_stall  = 1'b0;
      end
      else
      begin
         check_value("enabled_o", enabled_o, model_en);
         check_value("oflow_o", oflow_o, model_oflow);
         check_value("state_o", state_o, model_state);
         // Ack one cycle after each request, read data with it
         check_value("ack_o", ack_o, prev_req);
         if (prev_rd)
         begin
            check_value("dat_o", dat_o, exp_dat);
         end
         check_value("M_AXIS_TVALID", M_AXIS_TVALID,
                     (model_state == PKT_STREAM) && (ref_q.size() != 0));
         // Stalled word must hold still
         if (prev_stall)
         begin
            check_value("M_AXIS_TDATA", M_AXIS_TDATA, prev_tdata);
            check_value("M_AXIS_TLAST", M_AXIS_TLAST, prev_tlast);
         end
         check_value("M_AXIS_TLAST", M_AXIS_TLAST,
                     M_AXIS_TVALID && (word_cnt == PKT_WORDS - 1));
         handshake = M_AXIS_TVALID && M_AXIS_TREADY;
         if (handshake)
         begin
            check_value("M_AXIS_TDATA", M_AXIS_TDATA, TDATA_WIDTH'(ref_q[0]));
         end

         // Bus request seen this cycle, answered next cycle
         prev_req = cyc_i && stb_i;
         prev_rd  = cyc_i && stb_i && !we_i;
         sys_wr   = cyc_i && stb_i && we_i && (adr_i == AQ_SYSTEM);
         if (adr_i == AQ_SYSTEM)
         begin
            exp_dat = {model_en, model_state == PKT_STREAM, 2'b00, model_oflow, model_state};
         end
         else
         begin
            exp_dat = 8'h00;
         end

         // Full check happens before any pop of the same cycle
         capture = model_en && locked_i && strobe_i;
         drop    = capture && (ref_q.size() >= FIFO_DEPTH);
         if (handshake)
         begin
            void'(ref_q.pop_front());
            word_cnt = (word_cnt + 1) % PKT_WORDS;
         end
         if (capture && !drop)
         begin
            ref_q.push_back(signal_i);
         end

         // Drop beats a clear in the same cycle
         if (drop)
         begin
            model_oflow = 1'b1;
         end
         else if (sys_wr && dat_i[SYS_OFLOW])
         begin
            model_oflow = 1'b0;
         end
         if (sys_wr)
         begin
            model_en = dat_i[SYS_ENABLE];
         end

         case (model_state)
            PKT_IDLE:
            begin
               model_state = PKT_STREAM;
            end
            PKT_STREAM:
            begin
               if (handshake && M_AXIS_TLAST)
               begin
                  model_state = PKT_GAP;
               end
            end
            default:
            begin
               model_state = PKT_STREAM;
            end
         endcase

         prev_stall = M_AXIS_TVALID && !M_AXIS_TREADY;
         prev_tdata = M_AXIS_TDATA;
         prev_tlast = M_AXIS_TLAST;
      end
   end

   // -------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------
   initial
   begin
      M_AXIS_ARESETN = 1'b0;
      locked_i       = 1'b0;
      strobe_i       = 1'b0;
      signal_i       = '0;
      cyc_i          = 1'b0;
      stb_i          = 1'b0;
      we_i           = 1'b0;
      adr_i          = 2'd0;
      dat_i          = '0;
      M_AXIS_TREADY  = 1'b0;
      rng            = 32'h072a6b95;
      repeat (2) @(posedge clock_i);
      M_AXIS_ARESETN <= 1'b1;

      // Whole register map, back to back
      bus_issue(1'b0, AQ_STREAM, 8'h00);
      bus_issue(1'b0, AQ_RESERVED1, 8'h00);
      bus_issue(1'b0, AQ_RESERVED2, 8'h00);
      bus_issue(1'b0, AQ_SYSTEM, 8'h00);
      bus_release();

      // Strobes while disabled
      drive_samples(30, 1'b1, 1'b1, 1'b1);
      @(posedge clock_i);
      strobe_i <= 1'b0;
      bus_issue(1'b1, AQ_SYSTEM, 8'h80);
      bus_issue(1'b0, AQ_SYSTEM, 8'h00);
      bus_release();

      // Strobes while enabled but unlocked
      drive_samples(20, 1'b0, 1'b1, 1'b1);

      random_traffic(RAND_CYCLES);
      drain_stream();

      // Start from a clear flag so the first drop shows as a rise
      bus_issue(1'b1, AQ_SYSTEM, 8'h88);
      bus_release();

      // Overflow with the sink stalled
      drive_samples(FIFO_DEPTH + 4, 1'b1, 1'b0, 1'b0);
      drain_stream();

      // Clear the sticky flag, keep acquisition on
      bus_issue(1'b1, AQ_SYSTEM, 8'h88);
      bus_issue(1'b0, AQ_SYSTEM, 8'h00);
      bus_release();
      repeat (10) @(posedge clock_i);

      $display("Simulation finished: PASS");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(STIM_CYCLES * 4 + 400);
      $display("Watchdog expired before the test sequence completed");
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
   end

endmodule

// ==== src.f ====
acq_pkg.sv
acq_regs.sv
sample_fifo.sv
axis_packetizer.sv
raw_acquire.sv
tb_raw_acquire.sv

// ==== Makefile ====
TOP := tb_raw_acquire

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
